// ==== sim.f ====
design/mips_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_core.sv
verification/tb_mips_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mips core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f sim.f --top-module tb_mips_core \
   -Mdir obj_dir -o tb_mips_core \
   && ./obj_dir/tb_mips_core | tee sim.log
grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/tb_mips_core.sv ====
// mips core testbench: directed programs checked against a sequential reference model
`timescale 1ns/1ps

module tb_mips_core
   import mips_pkg::*;
();

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 10;
   localparam int DRAIN_CYCLES = 5;
   localparam int DMEM_WORDS   = 64;
   localparam int N_TESTS      = 6;
   // program lengths of all tests added up
   localparam int TOTAL_LEN    = 38;
   localparam int WATCHDOG_CYCLES =
      TOTAL_LEN + N_TESTS * (10 + RESET_CYCLES + DRAIN_CYCLES + 1);

   logic  clk;
   logic  rst_n;
   word_t instr_i = '0;
   word_t imem_addr_o;
   wb_t   wb_o;

   word_t       prog [64];
   int          prog_len;
   word_t       m_regs [32];
   word_t       m_mem [DMEM_WORDS];
   wb_t         exp_q [$];
   logic [31:0] rng_state = 32'd18411;
   int          err_count;
   int          check_count;
   int          test_count;

   mips_core #(
      .DMEM_WORDS (DMEM_WORDS)
   ) dut_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_i     (instr_i),
      .imem_addr_o (imem_addr_o),
      .wb_o        (wb_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // instruction memory answers one cycle after the address
   always @(posedge clk) begin
      if ((imem_addr_o >> 2) < word_t'(prog_len)) begin
         instr_i <= prog[imem_addr_o[7:2]];
      end else begin
         instr_i <= '0;
      end
   end

   function automatic word_t next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [15:0] rand_imm();
      word_t r;
      r = next_rand();
      return r[15:0];
   endfunction

   function automatic word_t r_type(funct_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
      return {6'h00, rs, rt, rd, 5'h00, fn};
   endfunction

   function automatic word_t i_type(opcode_e op, reg_idx_t rt, reg_idx_t rs,
                                    logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic emit(word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic check_wb(string name, wb_t got, wb_t exp);
      check_count++;
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_word(string name, word_t got, word_t exp);
      check_count++;
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         err_count++;
      end
   endtask

   // reset goes low, program is loaded while it is held
   task automatic hold_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      @(negedge clk);
      prog_len = 0;
   endtask

   task automatic release_reset();
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   // executes the program one instruction at a time
   task automatic run_model();
      word_t    ins;
      word_t    a;
      word_t    b;
      word_t    imm;
      word_t    res;
      logic     wr;
      reg_idx_t dest;
      int       idx;
      wb_t      ev;
      for (int i = 0; i < prog_len; i++) begin
         ins  = prog[i];
         a    = m_regs[ins[25:21]];
         b    = m_regs[ins[20:16]];
         imm  = {{16{ins[15]}}, ins[15:0]};
         idx  = int'(((a + imm) >> 2) % DMEM_WORDS);
         wr   = 1'b1;
         dest = ins[20:16];
         res  = '0;
         case (ins[31:26])
            6'h00: begin
               dest = ins[15:11];
               case (ins[5:0])
                  6'h20:   res = a + b;
                  6'h22:   res = a - b;
                  6'h24:   res = a & b;
                  6'h25:   res = a | b;
                  6'h2A:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: wr = 1'b0;
               endcase
            end
            6'h08: res = a + imm;
            6'h23: res = m_mem[idx];
            6'h2B: begin
               m_mem[idx] = b;
               wr         = 1'b0;
            end
            default: wr = 1'b0;
         endcase
         // writes to r0 are dropped
         if (wr && dest != 5'd0) begin
            ev.valid = 1'b1;
            ev.dest  = dest;
            ev.data  = res;
            exp_q.push_back(ev);
            m_regs[dest] = res;
         end
      end
   endtask

   task automatic collect_writes(int budget);
      wb_t exp;
      int  cycles;
      cycles = 0;
      while (exp_q.size() > 0 && cycles < budget) begin
         @(negedge clk);
         cycles++;
         if (wb_o.valid) begin
            exp = exp_q.pop_front();
            check_wb("wb_o", wb_o, exp);
         end
      end
      if (exp_q.size() > 0) begin
         $display("%0d expected writeback events never arrived", exp_q.size());
         err_count++;
         exp_q.delete();
      end else begin
         repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (wb_o.valid) begin
               $display("unexpected extra writeback event to register %0d", wb_o.dest);
               err_count++;
            end
         end
      end
   endtask

   task automatic finish_test(string name, int start_err);
      test_count++;
      if (err_count == start_err) begin
         $display("test %s passed", name);
      end else begin
         $display("test %s failed with %0d errors", name, err_count - start_err);
      end
   endtask

   task automatic run_program(string name, int start_err);
      release_reset();
      run_model();
      collect_writes(prog_len + 10);
      finish_test(name, start_err);
   endtask

   task automatic test_reset_fetch();
      int start;
      start = err_count;
      hold_reset();
      for (int i = 0; i < 4; i++) begin
         emit(i_type(OP_ADDI, 5'd1, 5'd0, rand_imm()));
      end
      release_reset();
      for (int k = 0; k < 5; k++) begin
         @(negedge clk);
         if (k == 0) begin
            check_word("wb_o.valid", {31'd0, wb_o.valid}, '0);
         end
         check_word("imem_addr_o", imem_addr_o, RESET_PC + word_t'(4 * k));
      end
      finish_test("reset_fetch", start);
   endtask

   task automatic test_alu_ops();
      int start;
      start = err_count;
      hold_reset();
      emit(i_type(OP_ADDI, 5'd1, 5'd0, rand_imm()));
      emit(i_type(OP_ADDI, 5'd2, 5'd0, rand_imm()));
      emit(i_type(OP_ADDI, 5'd3, 5'd0, rand_imm()));
      emit(i_type(OP_ADDI, 5'd4, 5'd0, rand_imm()));
      emit(r_type(FN_ADD, 5'd5, 5'd1, 5'd2));
      emit(r_type(FN_SUB, 5'd6, 5'd3, 5'd4));
      emit(r_type(FN_AND, 5'd7, 5'd1, 5'd3));
      emit(r_type(FN_OR, 5'd8, 5'd2, 5'd4));
      emit(r_type(FN_SLT, 5'd9, 5'd1, 5'd4));
      run_program("alu_ops", start);
   endtask

   // distance 1 from EX/MEM, 2 from MEM/WB, 3 through the register file
   task automatic test_dependencies();
      int start;
      start = err_count;
      hold_reset();
      emit(i_type(OP_ADDI, 5'd10, 5'd0, rand_imm()));
      emit(r_type(FN_ADD, 5'd11, 5'd10, 5'd10));
      emit(r_type(FN_OR, 5'd12, 5'd10, 5'd11));
      emit(r_type(FN_SLT, 5'd13, 5'd12, 5'd10));
      emit(r_type(FN_SUB, 5'd14, 5'd11, 5'd13));
      emit(r_type(FN_AND, 5'd15, 5'd14, 5'd12));
      run_program("dependencies", start);
   endtask

   task automatic test_store_load();
      int start;
      start = err_count;
      hold_reset();
      emit(i_type(OP_ADDI, 5'd20, 5'd0, rand_imm()));
      emit(i_type(OP_ADDI, 5'd21, 5'd0, rand_imm()));
      emit(i_type(OP_SW, 5'd20, 5'd0, 16'd8));
      emit(i_type(OP_SW, 5'd21, 5'd0, 16'd12));
      emit(i_type(OP_LW, 5'd22, 5'd0, 16'd12));
      emit(i_type(OP_LW, 5'd23, 5'd0, 16'd8));
      emit(i_type(OP_SW, 5'd23, 5'd0, 16'd16));
      emit(i_type(OP_LW, 5'd24, 5'd0, 16'd16));
      run_program("store_load", start);
   endtask

   task automatic test_load_use();
      int start;
      start = err_count;
      hold_reset();
      emit(i_type(OP_ADDI, 5'd1, 5'd0, rand_imm()));
      emit(i_type(OP_SW, 5'd1, 5'd0, 16'd32));
      emit(i_type(OP_LW, 5'd2, 5'd0, 16'd32));
      emit(r_type(FN_ADD, 5'd3, 5'd2, 5'd1));
      emit(i_type(OP_LW, 5'd4, 5'd0, 16'd32));
      emit(r_type(FN_SUB, 5'd5, 5'd1, 5'd4));
      run_program("load_use", start);
   endtask

   task automatic test_zero_reg();
      int start;
      start = err_count;
      hold_reset();
      emit(i_type(OP_ADDI, 5'd0, 5'd0, rand_imm()));
      emit(i_type(OP_ADDI, 5'd7, 5'd0, rand_imm()));
      emit(r_type(FN_ADD, 5'd0, 5'd7, 5'd7));
      // r0 sits in EX/MEM here and must not be forwarded
      emit(r_type(FN_ADD, 5'd8, 5'd0, 5'd7));
      emit(r_type(FN_OR, 5'd9, 5'd0, 5'd0));
      run_program("zero_reg", start);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired before the tests finished");
      $display("Checks failed");
      $finish;
   end

   initial begin
      rst_n = 1'b0;
      for (int i = 0; i < 32; i++) begin
         m_regs[i] = '0;
      end
      test_reset_fetch();
      test_alu_ops();
      test_dependencies();
      test_store_load();
      test_load_use();
      test_zero_reg();
      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== design/mips_core.sv ====
// mips core top: five-stage pipeline with external instruction memory
`timescale 1ns/1ps

module mips_core
   import mips_pkg::*;
#(
   parameter int DMEM_WORDS = 64
) (
   input  logic  clk,
   input  logic  rst_n,
   input  word_t instr_i,
   output word_t imem_addr_o,
   output wb_t   wb_o
);

   if_id_t  if_id;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   wb_t     mem_wb;
   logic    stall;

   fetch_stage fetch_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .stall_i     (stall),
      .instr_i     (instr_i),
      .imem_addr_o (imem_addr_o),
      .if_id_o     (if_id)
   );

   decode_stage decode_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .if_id_i (if_id),
      .wb_i    (mem_wb),
      .stall_o (stall),
      .id_ex_o (id_ex)
   );

   execute_stage execute_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .id_ex_i   (id_ex),
      .fwd_mem_i (mem_wb),
      .ex_mem_o  (ex_mem)
   );

   memory_stage #(
      .DMEM_WORDS (DMEM_WORDS)
   ) memory_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .ex_mem_i (ex_mem),
      .mem_wb_o (mem_wb)
   );

   // every register write is reported
   assign wb_o = mem_wb;

endmodule

// ==== design/memory_stage.sv ====
// memory stage: on-chip data memory, writeback select and MEM/WB register
`timescale 1ns/1ps

module memory_stage
   import mips_pkg::*;
#(
   parameter int DMEM_WORDS = 64
) (
   input  logic    clk,
   input  logic    rst_n,
   input  ex_mem_t ex_mem_i,
   output wb_t     mem_wb_o
);

   localparam int AW = $clog2(DMEM_WORDS);

   word_t          dmem [DMEM_WORDS];
   logic [AW-1:0]  word_idx;
   word_t          load_data;

   // word index sits above the byte offset
   assign word_idx  = ex_mem_i.alu_result[AW+1:2];
   assign load_data = dmem[word_idx];

   always_ff @(posedge clk) begin
      if (ex_mem_i.valid && ex_mem_i.mem_write) begin
         dmem[word_idx] <= ex_mem_i.store_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_wb_o.valid <= 1'b0;
      end else begin
         mem_wb_o.valid <= ex_mem_i.valid && ex_mem_i.reg_write;
         mem_wb_o.dest  <= ex_mem_i.dest;
         if (ex_mem_i.mem_read) begin
            mem_wb_o.data <= load_data;
         end else begin
            mem_wb_o.data <= ex_mem_i.alu_result;
         end
      end
   end

endmodule

// ==== design/execute_stage.sv ====
// execute stage: operand forwarding, ALU and EX/MEM register
`timescale 1ns/1ps

module execute_stage
   import mips_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  id_ex_t  id_ex_i,
   input  wb_t     fwd_mem_i,
   output ex_mem_t ex_mem_o
);

   word_t op_a;
   word_t rt_val;
   word_t op_b;
   word_t alu_res;

   // EX/MEM first, then MEM/WB, then the register value
   // a load in EX/MEM has no data yet
   function automatic word_t fwd_operand(reg_idx_t src, word_t reg_val);
      if (ex_mem_o.reg_write && !ex_mem_o.mem_read &&
          ex_mem_o.dest != '0 && ex_mem_o.dest == src) begin
         return ex_mem_o.alu_result;
      end else if (fwd_mem_i.valid && fwd_mem_i.dest != '0 &&
                   fwd_mem_i.dest == src) begin
         return fwd_mem_i.data;
      end
      return reg_val;
   endfunction

   always_comb begin
      op_a   = fwd_operand(id_ex_i.rs, id_ex_i.rs_data);
      rt_val = fwd_operand(id_ex_i.rt, id_ex_i.rt_data);
      op_b   = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rt_val;
   end

   always_comb begin
      case (id_ex_i.ctrl.alu_op)
         ALU_ADD: alu_res = op_a + op_b;
         ALU_SUB: alu_res = op_a - op_b;
         ALU_AND: alu_res = op_a & op_b;
         ALU_OR:  alu_res = op_a | op_b;
         ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
         default: alu_res = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_mem_o.valid     <= 1'b0;
         ex_mem_o.mem_read  <= 1'b0;
         ex_mem_o.mem_write <= 1'b0;
         ex_mem_o.reg_write <= 1'b0;
      end else begin
         ex_mem_o.valid      <= id_ex_i.valid;
         ex_mem_o.mem_read   <= id_ex_i.ctrl.mem_read;
         ex_mem_o.mem_write  <= id_ex_i.ctrl.mem_write;
         ex_mem_o.reg_write  <= id_ex_i.ctrl.reg_write;
         ex_mem_o.dest       <= id_ex_i.dest;
         ex_mem_o.alu_result <= alu_res;
         // store data goes through forwarding too
         ex_mem_o.store_data <= rt_val;
      end
   end

endmodule

// ==== design/decode_stage.sv ====
// decode stage: control decode, register file, load-use hazard and ID/EX register
`timescale 1ns/1ps

module decode_stage
   import mips_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  if_id_t if_id_i,
   input  wb_t    wb_i,
   output logic   stall_o,
   output id_ex_t id_ex_o
);

   opcode_e  opcode;
   funct_e   funct;
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t rd;
   reg_idx_t dest;
   ctrl_t    dec_ctrl;
   logic     known;
   logic     id_valid;
   id_ex_t   id_ex_d;

   word_t regs [32];

   assign opcode = opcode_e'(if_id_i.instr[31:26]);
   assign funct  = funct_e'(if_id_i.instr[5:0]);
   assign rs     = if_id_i.instr[25:21];
   assign rt     = if_id_i.instr[20:16];
   assign rd     = if_id_i.instr[15:11];
   assign dest   = (opcode == OP_RTYPE) ? rd : rt;

   // main control
   always_comb begin
      dec_ctrl = '{alu_op: ALU_ADD, default: 1'b0};
      known    = 1'b1;
      case (opcode)
         OP_RTYPE: begin
            dec_ctrl.reg_write = 1'b1;
            case (funct)
               FN_ADD:  dec_ctrl.alu_op = ALU_ADD;
               FN_SUB:  dec_ctrl.alu_op = ALU_SUB;
               FN_AND:  dec_ctrl.alu_op = ALU_AND;
               FN_OR:   dec_ctrl.alu_op = ALU_OR;
               FN_SLT:  dec_ctrl.alu_op = ALU_SLT;
               default: begin
                  dec_ctrl.reg_write = 1'b0;
                  known              = 1'b0;
               end
            endcase
         end
         OP_ADDI: begin
            dec_ctrl.use_imm   = 1'b1;
            dec_ctrl.reg_write = 1'b1;
         end
         OP_LW: begin
            dec_ctrl.use_imm   = 1'b1;
            dec_ctrl.mem_read  = 1'b1;
            dec_ctrl.reg_write = 1'b1;
         end
         OP_SW: begin
            dec_ctrl.use_imm   = 1'b1;
            dec_ctrl.mem_write = 1'b1;
         end
         default: known = 1'b0;
      endcase
   end

   // load in EX whose result is needed right now
   assign stall_o = if_id_i.valid && id_ex_o.valid && id_ex_o.ctrl.mem_read &&
                    (id_ex_o.dest == rs || id_ex_o.dest == rt);

   assign id_valid = if_id_i.valid && known && !stall_o;

   // read with write-through from writeback, r0 reads zero
   function automatic word_t read_reg(reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end else if (wb_i.valid && wb_i.dest == idx) begin
         return wb_i.data;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge clk) begin
      if (wb_i.valid && wb_i.dest != '0) begin
         regs[wb_i.dest] <= wb_i.data;
      end
   end

   always_comb begin
      id_ex_d                = '0;
      id_ex_d.valid          = id_valid;
      id_ex_d.ctrl           = dec_ctrl;
      id_ex_d.ctrl.mem_read  = dec_ctrl.mem_read && id_valid;
      id_ex_d.ctrl.mem_write = dec_ctrl.mem_write && id_valid;
      // r0 is never written, so no writeback either
      id_ex_d.ctrl.reg_write = dec_ctrl.reg_write && id_valid && dest != '0;
      id_ex_d.rs             = rs;
      id_ex_d.rt             = rt;
      id_ex_d.dest           = dest;
      id_ex_d.rs_data        = read_reg(rs);
      id_ex_d.rt_data        = read_reg(rt);
      id_ex_d.imm            = {{16{if_id_i.instr[15]}}, if_id_i.instr[15:0]};
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         id_ex_o.valid <= 1'b0;
         id_ex_o.ctrl  <= '{alu_op: ALU_ADD, default: 1'b0};
      end else begin
         id_ex_o <= id_ex_d;
      end
   end

endmodule

// ==== design/fetch_stage.sv ====
// fetch stage: program counter, fetch address re-issue on stall and IF/ID register
`timescale 1ns/1ps

module fetch_stage
   import mips_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   stall_i,
   input  word_t  instr_i,
   output word_t  imem_addr_o,
   output if_id_t if_id_o
);

   word_t pc;
   // address of the word arriving on instr_i this cycle
   word_t arr_pc;
   logic  fetch_pend;

   // a stalled word is dropped, so ask for it again
   assign imem_addr_o = stall_i ? arr_pc : pc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc         <= RESET_PC;
         arr_pc     <= RESET_PC;
         fetch_pend <= 1'b0;
      end else begin
         pc         <= imem_addr_o + 32'd4;
         arr_pc     <= imem_addr_o;
         fetch_pend <= 1'b1;
      end
   end

   // IF/ID holds while decode stalls
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         if_id_o.valid <= 1'b0;
      end else if (!stall_i) begin
         if_id_o.valid <= fetch_pend;
         if_id_o.pc    <= arr_pc;
         if_id_o.instr <= instr_i;
      end
   end

endmodule

// ==== design/mips_pkg.sv ====
// mips core package: shared word, opcode, control and pipeline record types
package mips_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   // first fetch address after reset
   localparam word_t RESET_PC = 32'h0000_0000;

   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_ADDI  = 6'h08,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2B
   } opcode_e;

   typedef enum logic [5:0] {
      FN_ADD = 6'h20,
      FN_SUB = 6'h22,
      FN_AND = 6'h24,
      FN_OR  = 6'h25,
      FN_SLT = 6'h2A
   } funct_e;

   // slt compares signed
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_e;

   typedef struct packed {
      logic  valid;
      word_t pc;
      word_t instr;
   } if_id_t;

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    mem_read;
      logic    mem_write;
      logic    reg_write;
   } ctrl_t;

   typedef struct packed {
      logic     valid;
      ctrl_t    ctrl;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t dest;
      word_t    rs_data;
      word_t    rt_data;
      word_t    imm;
   } id_ex_t;

   typedef struct packed {
      logic     valid;
      logic     mem_read;
      logic     mem_write;
      logic     reg_write;
      reg_idx_t dest;
      word_t    alu_result;
      word_t    store_data;
   } ex_mem_t;

   // valid here means a register is written
   typedef struct packed {
      logic     valid;
      reg_idx_t dest;
      word_t    data;
   } wb_t;

endpackage
